//--- flist.f
+incdir+include
logic/adv_pkg.sv
logic/adv_init_table.sv
logic/adv_sequencer.sv
logic/cts_monitor.sv
logic/adv7513_ctrl.sv
verif/adv_bus_model.sv
verif/tb_adv7513_ctrl.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module tb_adv7513_ctrl -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1

//--- verif/tb_adv7513_ctrl.sv
`timescale 1ns/1ps
`include "adv_defines.svh"

module tb_adv7513_ctrl import adv_pkg::*; ();

    localparam int        frame_window = 4;
    localparam int        num_frames   = 6;
    localparam reg_data_t video_17     = 8'h02;
    localparam reg_data_t video_3b     = 8'h80;
    localparam reg_data_t video_3c     = 8'h10;

    // five init runs in total, each with its PLL read, then the frame polls
    localparam int     init_runs   = 5;
    localparam int     worst_txn   = 10;
    localparam int     total_txns  = init_runs * (`ADV_INIT_LENGTH + 1) + num_frames * 3;
    localparam longint watchdog_ns = longint'(total_txns * worst_txn + 400) * 10 * 2;

    logic       clk;
    logic       reset;
    logic       hdmi_int;
    logic       vsync;
    logic       txn_start;
    logic       txn_read;
    reg_addr_t  txn_reg;
    reg_data_t  txn_wdata;
    logic       txn_done;
    reg_data_t  txn_rdata;
    logic       txn_ack_error;
    logic       ready;
    err_count_t pll_errors;
    cts_count_t cts_last_0, cts_last_1, cts_last_2;
    cts_count_t cts_max_0, cts_max_1, cts_max_2;
    cts_count_t cts_drop_0, cts_drop_1, cts_drop_2;
    logic [7:0]  pll_unlock_reads;
    logic [15:0] fail_txn;
    reg_data_t   cts_in [3];

    int          errors;
    int          checks;
    int          test_start;
    int          base;
    int          seed = 26;
    cts_count_t  ref_last [3];
    cts_count_t  ref_max [3];
    cts_count_t  ref_drop [3];
    logic [15:0] step;

    adv7513_ctrl #(.frame_window(frame_window)) uut (
        .clk(clk), .reset(reset), .hdmi_int(hdmi_int), .vsync(vsync),
        .reg_17(video_17), .reg_3b(video_3b), .reg_3c(video_3c),
        .txn_start(txn_start), .txn_read(txn_read), .txn_reg(txn_reg),
        .txn_wdata(txn_wdata), .txn_done(txn_done), .txn_rdata(txn_rdata),
        .txn_ack_error(txn_ack_error), .ready(ready), .pll_errors(pll_errors),
        .cts_last_0(cts_last_0), .cts_last_1(cts_last_1), .cts_last_2(cts_last_2),
        .cts_max_0(cts_max_0), .cts_max_1(cts_max_1), .cts_max_2(cts_max_2),
        .cts_drop_0(cts_drop_0), .cts_drop_1(cts_drop_1), .cts_drop_2(cts_drop_2)
    );

    adv_bus_model bus (
        .clk(clk), .reset(reset), .txn_start(txn_start), .txn_read(txn_read),
        .txn_reg(txn_reg), .txn_wdata(txn_wdata), .pll_unlock_reads(pll_unlock_reads),
        .fail_txn(fail_txn), .cts_in_0(cts_in[0]), .cts_in_1(cts_in[1]),
        .cts_in_2(cts_in[2]), .txn_done(txn_done), .txn_rdata(txn_rdata),
        .txn_ack_error(txn_ack_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RGB 4:4:4 power-up list as {register, value}
    function automatic logic [15:0] expected_write(input int idx);
        case (idx)
            0:  return {8'h41, 8'h10};
            1:  return {8'h98, 8'h03};
            2:  return {8'h9A, 8'hE0};
            3:  return {8'h9C, 8'h30};
            4:  return {8'h9D, 8'h01};
            5:  return {8'hA2, 8'hA4};
            6:  return {8'hA3, 8'hA4};
            7:  return {8'hE0, 8'hD0};
            8:  return {8'hF9, 8'h00};
            9:  return {8'h15, 8'h00};
            10: return {8'h17, video_17};
            11: return {8'h16, 8'h30};
            12: return {8'h55, 8'h00};
            13: return {8'h18, 8'h46};
            14: return {8'hAF, 8'h06};
            15: return {8'hBA, 8'h60};
            16: return {8'h0A, 8'h00};
            17: return {8'h01, 8'h00};
            18: return {8'h02, 8'h18};
            19: return {8'h03, 8'h80};
            20: return {8'h0B, 8'h0E};
            21: return {8'h0C, 8'h05};
            22: return {8'h0D, 8'h10};
            23: return {8'h94, 8'hC0};
            24: return {8'h96, 8'hC0};
            25: return {8'h3B, video_3b};
            26: return {8'h3C, video_3c};
            default: return 16'h0000;
        endcase
    endfunction

    // one sample on a channel, window clear first, result is {max, drop}
    function automatic logic [15:0] cts_step(input bit clear, input cts_count_t old_max,
                                             input cts_count_t old_drop,
                                             input cts_count_t value);
        cts_count_t m;
        cts_count_t d;
        m = clear ? 8'h00 : old_max;
        d = clear ? 8'h00 : old_drop;
        if (value >= m) begin
            m = value;
        end else if (8'(m - value) > d) begin
            d = 8'(m - value);
        end
        return {m, d};
    endfunction

    task automatic check_reg(input int pos, input reg_addr_t got_addr, input reg_data_t got_data,
                             input reg_addr_t exp_addr, input reg_data_t exp_data);
        checks++;
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            errors++;
            $display("[FAIL] %0t ns: write %0d was 0x%02h = 0x%02h, expected 0x%02h = 0x%02h",
                     $time, pos, got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    task automatic check_cts(input string what, input cts_count_t got, input cts_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input err_count_t got, input err_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // dup_at marks a logged write that the DUT had to send twice
    task automatic compare_log(input string what, input int from, input int length,
                               input int dup_at);
        int          idx;
        logic [23:0] word;
        logic [15:0] exp;
        checks++;
        if (bus.log_count - from != length) begin
            errors++;
            $display("[FAIL] %0t ns: %s logged %0d writes, expected %0d",
                     $time, what, bus.log_count - from, length);
        end
        for (int k = 0; k < length && from + k < bus.log_count; k++) begin
            idx = (dup_at >= 0 && k > dup_at) ? k - 1 : k;
            exp = expected_write(idx % `ADV_INIT_LENGTH);
            word = bus.log_word[from + k];
            check_reg(from + k, word[15:8], word[7:0], exp[15:8], exp[7:0]);
        end
    endtask

    task automatic wait_for_ready(input logic level, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (ready !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (ready !== level) begin
            errors++;
            $display("ready did not go to %0b within %0d cycles", level, max_cycles);
        end
    endtask

    task automatic wait_for_writes(input int target, input int max_cycles);
        int   n;
        logic early;
        n = 0;
        early = 1'b0;
        @(negedge clk);
        while (bus.log_count < target && n < max_cycles) begin
            if (ready !== 1'b0) begin
                early = 1'b1;
            end
            @(negedge clk);
            n++;
        end
        checks++;
        if (bus.log_count < target) begin
            errors++;
            $display("only %0d of %0d init writes arrived in time", bus.log_count, target);
        end
        if (early || ready !== 1'b0) begin
            errors++;
            $display("ready went high before the PLL status read");
        end
    endtask

    task automatic wait_for_reads(input int count, input int max_cycles);
        int n;
        int seen;
        n = 0;
        seen = 0;
        while (seen < count && n < max_cycles) begin
            @(negedge clk);
            if (txn_done && txn_read) begin
                seen++;
            end
            n++;
        end
        if (seen < count) begin
            errors++;
            $display("frame poll finished only %0d of %0d reads", seen, count);
        end
    endtask

    task automatic hot_plug_pulse();
        @(posedge clk);
        #1 hdmi_int = 1'b0;
        @(posedge clk);
        @(negedge clk);
        checks++;
        if (ready !== 1'b0) begin
            errors++;
            $display("[FAIL] %0t ns: ready still high a cycle after hdmi_int fell", $time);
        end
        @(posedge clk);
        #1 hdmi_int = 1'b1;
    endtask

    task automatic report_test(input string name);
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    initial begin : stimulus
        errors = 0;
        checks = 0;
        test_start = 0;
        reset = 1'b0;
        hdmi_int = 1'b1;
        vsync = 1'b0;
        pll_unlock_reads = 8'd2;
        fail_txn = 16'hFFFF;
        for (int ch = 0; ch < 3; ch++) begin
            cts_in[ch] = 8'h00;
            ref_last[ch] = 8'h00;
            ref_max[ch] = 8'h00;
            ref_drop[ch] = 8'h00;
        end
        repeat (3) @(posedge clk);
        #1 reset = 1'b1;

        // first pass of the power-up list, PLL reads still unlocked
        @(negedge clk);
        check_count("pll_errors after reset", pll_errors, 8'd0);
        wait_for_writes(`ADV_INIT_LENGTH, 1000);
        compare_log("first init run", 0, `ADV_INIT_LENGTH, -1);
        report_test("1 init writes");

        wait_for_ready(1'b1, 3000);
        check_count("pll_errors", pll_errors, 8'd2);
        compare_log("three init runs", 0, 3 * `ADV_INIT_LENGTH, -1);
        report_test("2 pll retries");

        // sixth write of the next run gets no acknowledge
        @(posedge clk);
        #1 fail_txn = 16'(bus.txn_count + 5);
        base = bus.log_count;
        hot_plug_pulse();
        wait_for_ready(1'b1, 1000);
        compare_log("re-init with ack error", base, `ADV_INIT_LENGTH + 1, 5);
        check_count("pll_errors", pll_errors, 8'd2);
        fail_txn = 16'hFFFF;
        report_test("3 ack retry");

        base = bus.log_count;
        hot_plug_pulse();
        wait_for_ready(1'b1, 1000);
        compare_log("hot plug re-init", base, `ADV_INIT_LENGTH, -1);
        report_test("4 hot plug");

        for (int f = 1; f <= num_frames; f++) begin
            @(posedge clk);
            #1;
            for (int ch = 0; ch < 3; ch++) begin
                cts_in[ch] = 8'($random(seed));
            end
            vsync = 1'b1;
            repeat (3) @(posedge clk);
            #1 vsync = 1'b0;
            wait_for_reads(3, 200);
            // sample strobe one cycle after the read, outputs one more
            repeat (2) @(posedge clk);
            @(negedge clk);
            for (int ch = 0; ch < 3; ch++) begin
                step = cts_step(f % frame_window == 0, ref_max[ch], ref_drop[ch], cts_in[ch]);
                ref_max[ch] = step[15:8];
                ref_drop[ch] = step[7:0];
                ref_last[ch] = cts_in[ch];
            end
            check_cts("cts_last_0", cts_last_0, ref_last[0]);
            check_cts("cts_last_1", cts_last_1, ref_last[1]);
            check_cts("cts_last_2", cts_last_2, ref_last[2]);
            check_cts("cts_max_0", cts_max_0, ref_max[0]);
            check_cts("cts_max_1", cts_max_1, ref_max[1]);
            check_cts("cts_max_2", cts_max_2, ref_max[2]);
            check_cts("cts_drop_0", cts_drop_0, ref_drop[0]);
            check_cts("cts_drop_1", cts_drop_1, ref_drop[1]);
            check_cts("cts_drop_2", cts_drop_2, ref_drop[2]);
        end
        report_test("5 cts monitor");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- verif/adv_bus_model.sv
`timescale 1ns/1ps
`include "adv_defines.svh"

module adv_bus_model import adv_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        txn_start,
    input  logic        txn_read,
    input  reg_addr_t   txn_reg,
    input  reg_data_t   txn_wdata,
    input  logic [7:0]  pll_unlock_reads,
    input  logic [15:0] fail_txn,
    input  reg_data_t   cts_in_0,
    input  reg_data_t   cts_in_1,
    input  reg_data_t   cts_in_2,
    output logic        txn_done,
    output reg_data_t   txn_rdata,
    output logic        txn_ack_error
);

    // first byte on the wire, device address with the write flag
    localparam logic [7:0] dev_byte = {`ADV_CHIP_ADDR, 1'b0};

    reg_data_t   reg_mem [256];
    // each entry holds device byte, register and data as sent
    logic [23:0] log_word [256];
    int          log_count;
    int          txn_count;
    int          pll_reads;
    int          lat_seed = 26;
    logic        busy;
    int          wait_left;
    logic        cur_read;
    reg_addr_t   cur_reg;
    reg_data_t   cur_data;

    always @(posedge clk) begin : respond
        logic      ack_err;
        reg_data_t rd;
        txn_done      <= 1'b0;
        txn_ack_error <= 1'b0;
        if (!reset) begin
            busy      <= 1'b0;
            wait_left <= 0;
            log_count <= 0;
            txn_count <= 0;
            pll_reads <= 0;
            txn_rdata <= '0;
            for (int i = 0; i < 256; i++) begin
                reg_mem[i] <= 8'(i) ^ 8'hA5;
            end
        end else if (busy) begin
            if (wait_left == 0) begin
                ack_err = (txn_count == int'(fail_txn));
                rd = reg_mem[cur_reg];
                if (cur_reg == `ADV_REG_PLL_STATUS) begin
                    rd[`ADV_PLL_LOCK_BIT] = (pll_reads >= int'(pll_unlock_reads));
                end else if (cur_reg == `ADV_REG_CTS_FIRST) begin
                    rd = cts_in_0;
                end else if (cur_reg == `ADV_REG_CTS_FIRST + 8'd1) begin
                    rd = cts_in_1;
                end else if (cur_reg == `ADV_REG_CTS_FIRST + 8'd2) begin
                    rd = cts_in_2;
                end
                txn_done      <= 1'b1;
                txn_ack_error <= ack_err;
                txn_count     <= txn_count + 1;
                busy          <= 1'b0;
                if (cur_read) begin
                    txn_rdata <= rd;
                    if (cur_reg == `ADV_REG_PLL_STATUS && !ack_err) begin
                        pll_reads <= pll_reads + 1;
                    end
                end else if (!ack_err) begin
                    reg_mem[cur_reg] <= cur_data;
                end
            end else begin
                wait_left <= wait_left - 1;
            end
        end else if (txn_start) begin
            busy     <= 1'b1;
            cur_read <= txn_read;
            cur_reg  <= txn_reg;
            cur_data <= txn_wdata;
            // answer 1 to 6 cycles after the start strobe
            wait_left <= int'($unsigned($random(lat_seed)) % 6);
            if (!txn_read) begin
                log_word[log_count] <= {dev_byte, txn_reg, txn_wdata};
                log_count           <= log_count + 1;
            end
        end
    end

endmodule

//--- logic/adv7513_ctrl.sv
`timescale 1ns/1ps
`include "adv_defines.svh"

module adv7513_ctrl import adv_pkg::*; #(
    parameter int frame_window = `ADV_FRAME_WINDOW
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       hdmi_int,
    input  logic       vsync,
    input  reg_data_t  reg_17,
    input  reg_data_t  reg_3b,
    input  reg_data_t  reg_3c,
    output logic       txn_start,
    output logic       txn_read,
    output reg_addr_t  txn_reg,
    output reg_data_t  txn_wdata,
    input  logic       txn_done,
    input  reg_data_t  txn_rdata,
    input  logic       txn_ack_error,
    output logic       ready,
    output err_count_t pll_errors,
    output cts_count_t cts_last_0,
    output cts_count_t cts_last_1,
    output cts_count_t cts_last_2,
    output cts_count_t cts_max_0,
    output cts_count_t cts_max_1,
    output cts_count_t cts_max_2,
    output cts_count_t cts_drop_0,
    output cts_count_t cts_drop_1,
    output cts_count_t cts_drop_2
);

    cmd_index_t cmd_index;
    reg_addr_t  table_reg;
    reg_data_t  table_data;
    logic       cts_sample;
    logic       frame_tick;
    cts_sel_t   cts_sel;
    cts_count_t cts_value;

    adv_init_table u_table (
        .cmd_index  (cmd_index),
        .reg_17     (reg_17),
        .reg_3b     (reg_3b),
        .reg_3c     (reg_3c),
        .table_reg  (table_reg),
        .table_data (table_data)
    );

    adv_sequencer u_seq (
        .clk           (clk),
        .reset         (reset),
        .hdmi_int      (hdmi_int),
        .vsync         (vsync),
        .cmd_index     (cmd_index),
        .table_reg     (table_reg),
        .table_data    (table_data),
        .txn_start     (txn_start),
        .txn_read      (txn_read),
        .txn_reg       (txn_reg),
        .txn_wdata     (txn_wdata),
        .txn_done      (txn_done),
        .txn_ack_error (txn_ack_error),
        .txn_rdata     (txn_rdata),
        .ready         (ready),
        .pll_errors    (pll_errors),
        .cts_sample    (cts_sample),
        .frame_tick    (frame_tick),
        .cts_sel       (cts_sel),
        .cts_value     (cts_value)
    );

    cts_monitor #(
        .frame_window (frame_window)
    ) u_mon (
        .clk        (clk),
        .reset      (reset),
        .cts_sample (cts_sample),
        .frame_tick (frame_tick),
        .cts_sel    (cts_sel),
        .cts_value  (cts_value),
        .cts_last_0 (cts_last_0),
        .cts_last_1 (cts_last_1),
        .cts_last_2 (cts_last_2),
        .cts_max_0  (cts_max_0),
        .cts_max_1  (cts_max_1),
        .cts_max_2  (cts_max_2),
        .cts_drop_0 (cts_drop_0),
        .cts_drop_1 (cts_drop_1),
        .cts_drop_2 (cts_drop_2)
    );

endmodule

//--- logic/cts_monitor.sv
`timescale 1ns/1ps
`include "adv_defines.svh"

module cts_monitor import adv_pkg::*; #(
    parameter int frame_window = `ADV_FRAME_WINDOW
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cts_sample,
    input  logic       frame_tick,
    input  cts_sel_t   cts_sel,
    input  cts_count_t cts_value,
    output cts_count_t cts_last_0,
    output cts_count_t cts_last_1,
    output cts_count_t cts_last_2,
    output cts_count_t cts_max_0,
    output cts_count_t cts_max_1,
    output cts_count_t cts_max_2,
    output cts_count_t cts_drop_0,
    output cts_count_t cts_drop_1,
    output cts_count_t cts_drop_2
);

    localparam int cnt_w = $clog2(frame_window + 1);

    cts_count_t last_q [`ADV_CTS_CHANNELS];
    cts_count_t max_q  [`ADV_CTS_CHANNELS];
    cts_count_t drop_q [`ADV_CTS_CHANNELS];

    logic [cnt_w-1:0] frame_count;

    always_ff @(posedge clk) begin
        if (!reset) begin
            frame_count <= '0;
            for (int ch = 0; ch < `ADV_CTS_CHANNELS; ch++) begin
                last_q[ch] <= '0;
                max_q[ch]  <= '0;
                drop_q[ch] <= '0;
            end
        end else if (frame_tick) begin
            if (frame_count == cnt_w'(frame_window - 1)) begin
                // window closed, start collecting peaks afresh
                frame_count <= '0;
                for (int ch = 0; ch < `ADV_CTS_CHANNELS; ch++) begin
                    max_q[ch]  <= '0;
                    drop_q[ch] <= '0;
                end
            end else begin
                frame_count <= frame_count + 1'b1;
            end
        end else if (cts_sample) begin
            for (int ch = 0; ch < `ADV_CTS_CHANNELS; ch++) begin
                if (cts_sel == cts_sel_t'(ch)) begin
                    last_q[ch] <= cts_value;
                    if (cts_value >= max_q[ch]) begin
                        max_q[ch] <= cts_value;
                    end else if ((max_q[ch] - cts_value) > drop_q[ch]) begin
                        // deepest dip below the peak seen so far
                        drop_q[ch] <= max_q[ch] - cts_value;
                    end
                end
            end
        end
    end

    assign cts_last_0 = last_q[0];
    assign cts_last_1 = last_q[1];
    assign cts_last_2 = last_q[2];
    assign cts_max_0  = max_q[0];
    assign cts_max_1  = max_q[1];
    assign cts_max_2  = max_q[2];
    assign cts_drop_0 = drop_q[0];
    assign cts_drop_1 = drop_q[1];
    assign cts_drop_2 = drop_q[2];

    // the sequencer ticks the frame before its first poll read returns
    a_no_overlap: assert property (@(posedge clk) disable iff (!reset)
        !(cts_sample && frame_tick));

endmodule

//--- logic/adv_sequencer.sv
`timescale 1ns/1ps
`include "adv_defines.svh"

module adv_sequencer import adv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       hdmi_int,
    input  logic       vsync,
    output cmd_index_t cmd_index,
    input  reg_addr_t  table_reg,
    input  reg_data_t  table_data,
    output logic       txn_start,
    output logic       txn_read,
    output reg_addr_t  txn_reg,
    output reg_data_t  txn_wdata,
    input  logic       txn_done,
    input  logic       txn_ack_error,
    input  reg_data_t  txn_rdata,
    output logic       ready,
    output err_count_t pll_errors,
    output logic       cts_sample,
    output logic       frame_tick,
    output cts_sel_t   cts_sel,
    output cts_count_t cts_value
);

    seq_state_t state;

    logic     vsync_q;
    logic     vsync_prev;
    logic     vsync_rise;
    logic     polling;
    logic     frame_pending;
    cts_sel_t poll_chan;
    logic     txn_busy;

    // two flops also bring vsync into the clk domain
    assign vsync_rise = vsync_q & ~vsync_prev;

    always_ff @(posedge clk) begin
        if (!reset) begin
            vsync_q    <= 1'b0;
            vsync_prev <= 1'b0;
        end else begin
            vsync_q    <= vsync;
            vsync_prev <= vsync_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state         <= seq_issue;
            cmd_index     <= '0;
            txn_start     <= 1'b0;
            ready         <= 1'b0;
            pll_errors    <= '0;
            polling       <= 1'b0;
            frame_pending <= 1'b0;
            poll_chan     <= '0;
            cts_sample    <= 1'b0;
            frame_tick    <= 1'b0;
            cts_sel       <= '0;
        end else begin
            txn_start  <= 1'b0;
            cts_sample <= 1'b0;
            frame_tick <= 1'b0;

            case (state)
                seq_issue: begin
                    txn_start <= 1'b1;
                    if (polling) begin
                        txn_read      <= 1'b1;
                        txn_reg       <= `ADV_REG_CTS_FIRST + {6'd0, poll_chan};
                        txn_wdata     <= 8'h00;
                        frame_tick    <= frame_pending;
                        frame_pending <= 1'b0;
                        state         <= seq_poll;
                    end else if (cmd_index == cmd_index_t'(`ADV_INIT_LENGTH)) begin
                        txn_read  <= 1'b1;
                        txn_reg   <= `ADV_REG_PLL_STATUS;
                        txn_wdata <= 8'h00;
                        state     <= seq_check_pll;
                    end else begin
                        txn_read  <= 1'b0;
                        txn_reg   <= table_reg;
                        txn_wdata <= table_data;
                        state     <= seq_wait;
                    end
                end

                seq_wait: begin
                    // an acked-out write goes back to issue with the same index
                    if (txn_done) begin
                        if (!txn_ack_error) begin
                            cmd_index <= cmd_index + 5'd1;
                        end
                        state <= seq_issue;
                    end
                end

                seq_check_pll: begin
                    if (txn_done) begin
                        if (txn_ack_error) begin
                            state <= seq_issue;
                        end else if (txn_rdata[`ADV_PLL_LOCK_BIT]) begin
                            ready     <= 1'b1;
                            cmd_index <= '0;
                            state     <= seq_ready;
                        end else begin
                            // not locked, run the whole write list again
                            pll_errors <= pll_errors + 8'd1;
                            cmd_index  <= '0;
                            state      <= seq_issue;
                        end
                    end
                end

                seq_ready: begin
                    if (!hdmi_int) begin
                        state <= seq_issue;
                    end else if (vsync_rise) begin
                        polling       <= 1'b1;
                        frame_pending <= 1'b1;
                        poll_chan     <= '0;
                        state         <= seq_issue;
                    end
                end

                seq_poll: begin
                    if (txn_done) begin
                        if (txn_ack_error) begin
                            state <= seq_issue;
                        end else if (!ready) begin
                            // hot plug arrived mid poll, drop the result and re-init
                            polling <= 1'b0;
                            state   <= seq_issue;
                        end else begin
                            cts_sample <= 1'b1;
                            cts_sel    <= poll_chan;
                            cts_value  <= txn_rdata;
                            if (poll_chan == cts_sel_t'(`ADV_CTS_CHANNELS - 1)) begin
                                polling <= 1'b0;
                                state   <= seq_ready;
                            end else begin
                                poll_chan <= poll_chan + 2'd1;
                                state     <= seq_issue;
                            end
                        end
                    end
                end

                default: begin
                    state <= seq_issue;
                end
            endcase

            // hot plug overrides whatever the case above decided
            if (ready && !hdmi_int) begin
                ready   <= 1'b0;
                polling <= 1'b0;
            end
        end
    end

    // one transaction in flight with the external engine
    always_ff @(posedge clk) begin
        if (!reset) begin
            txn_busy <= 1'b0;
        end else if (txn_start) begin
            txn_busy <= 1'b1;
        end else if (txn_done) begin
            txn_busy <= 1'b0;
        end
    end

    a_single_txn: assert property (@(posedge clk) disable iff (!reset)
        txn_start |-> !txn_busy);

    a_cts_sel_range: assert property (@(posedge clk) disable iff (!reset)
        cts_sel <= cts_sel_t'(`ADV_CTS_CHANNELS - 1));

endmodule

//--- logic/adv_init_table.sv
`timescale 1ns/1ps

module adv_init_table import adv_pkg::*; (
    input  cmd_index_t cmd_index,
    input  reg_data_t  reg_17,
    input  reg_data_t  reg_3b,
    input  reg_data_t  reg_3c,
    output reg_addr_t  table_reg,
    output reg_data_t  table_data
);

    always_comb begin
        table_reg  = 8'h00;
        table_data = 8'h00;
        case (cmd_index)
            // power up all circuits, sync adjust off
            5'd0:  begin table_reg = 8'h41; table_data = 8'h10; end
            // fixed registers from the programming guide
            5'd1:  begin table_reg = 8'h98; table_data = 8'h03; end
            5'd2:  begin table_reg = 8'h9A; table_data = 8'hE0; end
            5'd3:  begin table_reg = 8'h9C; table_data = 8'h30; end
            5'd4:  begin table_reg = 8'h9D; table_data = 8'h01; end
            5'd5:  begin table_reg = 8'hA2; table_data = 8'hA4; end
            5'd6:  begin table_reg = 8'hA3; table_data = 8'hA4; end
            5'd7:  begin table_reg = 8'hE0; table_data = 8'hD0; end
            5'd8:  begin table_reg = 8'hF9; table_data = 8'h00; end
            // 44.1 kHz I2S, 24 bit RGB 4:4:4 with separate syncs
            5'd9:  begin table_reg = 8'h15; table_data = 8'h00; end
            // sync polarity and aspect ratio come from the video config
            5'd10: begin table_reg = 8'h17; table_data = reg_17; end
            // 4:4:4 output, 8 bit colour depth
            5'd11: begin table_reg = 8'h16; table_data = 8'h30; end
            // RGB in the AVI infoframe, colour space converter off
            5'd12: begin table_reg = 8'h55; table_data = 8'h00; end
            5'd13: begin table_reg = 8'h18; table_data = 8'h46; end
            // HDMI mode, HDCP off
            5'd14: begin table_reg = 8'hAF; table_data = 8'h06; end
            // no clock delay, external HDCP eeprom
            5'd15: begin table_reg = 8'hBA; table_data = 8'h60; end
            // automatic CTS, I2S audio, 128xfs MCLK
            5'd16: begin table_reg = 8'h0A; table_data = 8'h00; end
            // audio N = 0x01880 (6272) for 44.1 kHz
            5'd17: begin table_reg = 8'h01; table_data = 8'h00; end
            5'd18: begin table_reg = 8'h02; table_data = 8'h18; end
            5'd19: begin table_reg = 8'h03; table_data = 8'h80; end
            // SPDIF off, MCLK generated inside
            5'd20: begin table_reg = 8'h0B; table_data = 8'h0E; end
            // I2S0 only, right justified, 16 bit words
            5'd21: begin table_reg = 8'h0C; table_data = 8'h05; end
            5'd22: begin table_reg = 8'h0D; table_data = 8'h10; end
            // enable HPD and monitor sense interrupts, then clear them
            5'd23: begin table_reg = 8'h94; table_data = 8'hC0; end
            5'd24: begin table_reg = 8'h96; table_data = 8'hC0; end
            // pixel repetition and VIC from the video config
            5'd25: begin table_reg = 8'h3B; table_data = reg_3b; end
            5'd26: begin table_reg = 8'h3C; table_data = reg_3c; end
            default: begin
                table_reg  = 8'h00;
                table_data = 8'h00;
            end
        endcase
    end

endmodule

//--- logic/adv_pkg.sv
package adv_pkg;

    // register file address and data byte on the transmitter
    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;

    // position in the power-up write table
    typedef logic [4:0] cmd_index_t;

    // CTS channel number, 0 to 2
    typedef logic [1:0] cts_sel_t;

    // CTS status byte, also used for running max and drop
    typedef logic [7:0] cts_count_t;

    // number of PLL lock failures since reset
    typedef logic [7:0] err_count_t;

    typedef enum logic [2:0] {
        seq_issue,
        seq_wait,
        seq_check_pll,
        seq_ready,
        seq_poll
    } seq_state_t;

endpackage

//--- include/adv_defines.svh
`ifndef ADV_DEFINES_SVH
`define ADV_DEFINES_SVH

// 7-bit I2C address of the transmitter, PD pin low
`define ADV_CHIP_ADDR 7'h39

// number of register writes in the power-up sequence
`define ADV_INIT_LENGTH 27

// PLL status register and its lock flag
`define ADV_REG_PLL_STATUS 8'h9E
`define ADV_PLL_LOCK_BIT 4

// audio CTS status, channel n sits at this address plus n
`define ADV_REG_CTS_FIRST 8'h04
`define ADV_CTS_CHANNELS 3

// frames between clears of the CTS maxima and drops
`define ADV_FRAME_WINDOW 1024

`endif
